// ==== rab_pkg.sv ====
// shared widths, AXI4-Lite bundles and translation types
// for the address remapping block
package rab_pkg;

  localparam int N_SLICES       = 4;
  localparam int REGS_PER_SLICE = 4;
  localparam int VIRT_ADDR_W    = 32;
  localparam int PHYS_ADDR_W    = 40;
  localparam int CFG_DATA_W     = 64;
  localparam int CFG_ADDR_W     = 32;
  localparam int LEN_W          = 8;
  localparam int SIZE_W         = 3;
  localparam int CTRL_W         = 6;
  localparam int BEAT_BYTES_W   = 3;

  // register order inside one slice
  localparam int REG_START  = 0;
  localparam int REG_END    = 1;
  localparam int REG_OFFSET = 2;
  localparam int REG_FLAGS  = 3;

  localparam int N_CFG_REGS = N_SLICES * REGS_PER_SLICE;
  localparam int CFG_IDX_W  = $clog2(N_CFG_REGS);
  localparam int CFG_OFS_W  = $clog2(CFG_DATA_W / 8);  // byte offset inside a word

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef struct packed {
    logic wr_ok;
    logic rd_ok;
    logic en;                                           // bit 0
  } cfg_flags_t;

  // a slice register is either an address or a flags word
  typedef union packed {
    struct packed {
      logic [CFG_DATA_W-PHYS_ADDR_W-1:0] pad;
      logic [PHYS_ADDR_W-1:0]            addr;
    } addr_v;
    struct packed {
      logic [CFG_DATA_W-$bits(cfg_flags_t)-1:0] pad;
      cfg_flags_t                               flags;
    } flags_v;
  } cfg_word_u;

  typedef struct packed {
    logic [VIRT_ADDR_W-1:0] start;
    logic [VIRT_ADDR_W-1:0] last;     // inclusive upper bound
    logic [PHYS_ADDR_W-1:0] offset;
    cfg_flags_t             flags;
  } slice_cfg_t;

  typedef struct packed {
    logic [VIRT_ADDR_W-1:0] addr;
    logic [LEN_W-1:0]       len;
    logic [SIZE_W-1:0]      size;
    logic [CTRL_W-1:0]      ctrl;
  } xlate_req_t;

  typedef struct packed {
    logic [VIRT_ADDR_W-1:0] addr_min;
    logic [VIRT_ADDR_W-1:0] addr_max;
    logic                   is_write;
    logic                   skip;
  } lookup_t;

  typedef struct packed {
    logic                   any_hit;
    logic                   multi;
    logic                   prot_fail;
    logic                   skip;
    logic [PHYS_ADDR_W-1:0] out_addr;
  } match_t;

  typedef struct packed {
    logic [CFG_ADDR_W-1:0]   awaddr;
    logic                    awvalid;
    logic [CFG_DATA_W-1:0]   wdata;
    logic [CFG_DATA_W/8-1:0] wstrb;
    logic                    wvalid;
    logic                    bready;
    logic [CFG_ADDR_W-1:0]   araddr;
    logic                    arvalid;
    logic                    rready;
  } axil_req_t;

  typedef struct packed {
    logic                  awready;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  arready;
    logic [CFG_DATA_W-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
  } axil_rsp_t;

endpackage

// ==== rab_cfg_regs.sv ====
// AXI4-Lite slave holding the slice registers
// and decoding them into per-slice configuration
`timescale 1ns/1ps

module rab_cfg_regs import rab_pkg::*;
(
  input  logic                       Clk_CI,
  input  logic                       Rst_RBI,
  input  axil_req_t                  axil_req,
  output axil_rsp_t                  axil_rsp,
  output slice_cfg_t [N_SLICES-1:0]  slice_cfg
);

  logic [CFG_DATA_W-1:0] cfg_q [N_CFG_REGS];

  logic                  wr_fire;
  logic                  rd_fire;
  logic                  wr_in_range;
  logic                  rd_in_range;
  logic [CFG_IDX_W-1:0]  wr_idx;
  logic [CFG_IDX_W-1:0]  rd_idx;

  logic                  bvalid_q;
  logic [1:0]            bresp_q;
  logic                  rvalid_q;
  logic [1:0]            rresp_q;
  logic [CFG_DATA_W-1:0] rdata_q;

  // one response outstanding per direction
  assign wr_fire = axil_req.awvalid & axil_req.wvalid & ~bvalid_q;
  assign rd_fire = axil_req.arvalid & ~rvalid_q;

  assign wr_in_range = axil_req.awaddr < CFG_ADDR_W'(N_CFG_REGS * CFG_DATA_W / 8);
  assign rd_in_range = axil_req.araddr < CFG_ADDR_W'(N_CFG_REGS * CFG_DATA_W / 8);
  assign wr_idx      = axil_req.awaddr[CFG_OFS_W +: CFG_IDX_W];
  assign rd_idx      = axil_req.araddr[CFG_OFS_W +: CFG_IDX_W];

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      for (int i = 0; i < N_CFG_REGS; i++)
        cfg_q[i] <= '0;                     // all slices disabled
    end
    else if (wr_fire && wr_in_range)
    begin
      for (int b = 0; b < CFG_DATA_W / 8; b++)
      begin
        if (axil_req.wstrb[b])
          cfg_q[wr_idx][8*b +: 8] <= axil_req.wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end
    else
    begin
      if (wr_fire)
        bvalid_q <= 1'b1;
      else if (axil_req.bready)
        bvalid_q <= 1'b0;
      if (rd_fire)
        rvalid_q <= 1'b1;
      else if (axil_req.rready)
        rvalid_q <= 1'b0;
    end
  end

  // response payload
  always_ff @(posedge Clk_CI)
  begin
    if (wr_fire)
      bresp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
    if (rd_fire)
    begin
      rresp_q <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
      rdata_q <= rd_in_range ? cfg_q[rd_idx] : '0;
    end
  end

  always_comb
  begin
    axil_rsp.awready = wr_fire;
    axil_rsp.wready  = wr_fire;
    axil_rsp.bresp   = bresp_q;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.arready = rd_fire;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
    axil_rsp.rvalid  = rvalid_q;
  end

  // address and flags views of the stored words
  always_comb
  begin
    cfg_word_u w_start;
    cfg_word_u w_end;
    cfg_word_u w_ofs;
    cfg_word_u w_flags;
    for (int k = 0; k < N_SLICES; k++)
    begin
      w_start = cfg_q[k*REGS_PER_SLICE + REG_START];
      w_end   = cfg_q[k*REGS_PER_SLICE + REG_END];
      w_ofs   = cfg_q[k*REGS_PER_SLICE + REG_OFFSET];
      w_flags = cfg_q[k*REGS_PER_SLICE + REG_FLAGS];
      slice_cfg[k].start  = w_start.addr_v.addr[VIRT_ADDR_W-1:0];
      slice_cfg[k].last   = w_end.addr_v.addr[VIRT_ADDR_W-1:0];
      slice_cfg[k].offset = w_ofs.addr_v.addr;
      slice_cfg[k].flags  = w_flags.flags_v.flags;
    end
  end

endmodule

// ==== rab_req_arbiter.sv ====
// read/write request arbiter with alternating priority,
// burst range computation and lookup register
`timescale 1ns/1ps

module rab_req_arbiter import rab_pkg::*;
(
  input  logic       Clk_CI,
  input  logic       Rst_RBI,
  input  xlate_req_t rd_req,
  input  xlate_req_t wr_req,
  input  logic       rd_valid,
  input  logic       wr_valid,
  input  logic       take,
  output lookup_t    lookup,
  output logic       lookup_valid,
  output logic       served_write
);

  logic                    rd_prio_q;   // read channel wins a tie
  logic                    busy_q;      // item in flight, FSM not yet responding
  logic                    sel_rd;
  logic                    capture;
  xlate_req_t              req;
  logic [BEAT_BYTES_W-1:0] mask;
  logic [VIRT_ADDR_W-1:0]  addr_align;
  logic [VIRT_ADDR_W-1:0]  burst_bytes;
  lookup_t                 lookup_d;

  assign sel_rd  = (rd_valid & rd_prio_q) | ~wr_valid;
  assign req     = sel_rd ? rd_req : wr_req;
  assign capture = take & ~busy_q & (rd_valid | wr_valid);

  always_comb
  begin
    case (req.size)
      3'd0:    mask = 3'b111;
      3'd1:    mask = 3'b110;
      3'd2:    mask = 3'b100;
      default: mask = 3'b000;   // 8 bytes and wider
    endcase
    addr_align  = {req.addr[VIRT_ADDR_W-1:BEAT_BYTES_W], req.addr[BEAT_BYTES_W-1:0] & mask};
    burst_bytes = (VIRT_ADDR_W'(req.len) + 1) << req.size;

    lookup_d.addr_min = req.addr;
    lookup_d.addr_max = addr_align + burst_bytes - 1;
    lookup_d.is_write = ~sel_rd;
    lookup_d.skip     = &req.ctrl;  // ctrl all ones bypasses translation
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      rd_prio_q    <= 1'b0;          // write first
      busy_q       <= 1'b0;
      lookup_valid <= 1'b0;
    end
    else
    begin
      lookup_valid <= capture;
      if (capture)
      begin
        busy_q    <= 1'b1;
        rd_prio_q <= ~sel_rd;        // served channel yields to the other
      end
      else if (!take)
        busy_q <= 1'b0;              // FSM has left idle
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (capture)
      lookup <= lookup_d;
  end

  assign served_write = lookup.is_write;

endmodule

// ==== rab_slice_match.sv ====
// range and protection compare against all slices,
// hit counting and offset translation
`timescale 1ns/1ps

module rab_slice_match import rab_pkg::*;
(
  input  logic                      Clk_CI,
  input  logic                      Rst_RBI,
  input  slice_cfg_t [N_SLICES-1:0] slice_cfg,
  input  lookup_t                   lookup,
  input  logic                      lookup_valid,
  output match_t                    match,
  output logic                      match_valid
);

  logic [N_SLICES-1:0] hit;
  logic [N_SLICES-1:0] prot;
  match_t              match_d;

  always_comb
  begin
    int unsigned n_hits;
    n_hits  = 0;
    match_d = '0;
    for (int k = 0; k < N_SLICES; k++)
    begin
      hit[k]  = slice_cfg[k].flags.en
                & (lookup.addr_min >= slice_cfg[k].start)
                & (lookup.addr_max <= slice_cfg[k].last);
      prot[k] = hit[k] & ~(lookup.is_write ? slice_cfg[k].flags.wr_ok
                                           : slice_cfg[k].flags.rd_ok);
      if (hit[k])
      begin
        n_hits           = n_hits + 1;
        match_d.out_addr = slice_cfg[k].offset
                           + PHYS_ADDR_W'(lookup.addr_min - slice_cfg[k].start);
      end
    end
    match_d.any_hit   = |hit;
    match_d.multi     = n_hits > 1;
    match_d.prot_fail = |prot;
    match_d.skip      = lookup.skip;
    if (lookup.skip)
      match_d.out_addr = PHYS_ADDR_W'(lookup.addr_min);   // untranslated
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      match_valid <= 1'b0;
    else
      match_valid <= lookup_valid;
  end

  always_ff @(posedge Clk_CI)
  begin
    if (lookup_valid)
      match <= match_d;
  end

endmodule

// ==== rab_xlate_fsm.sv ====
// response FSM: accept or drop held until sent,
// one-cycle interrupt pulses on drop
`timescale 1ns/1ps

module rab_xlate_fsm import rab_pkg::*;
(
  input  logic                   Clk_CI,
  input  logic                   Rst_RBI,
  input  match_t                 match,
  input  logic                   match_valid,
  input  logic                   served_write,
  input  logic                   rd_sent,
  input  logic                   wr_sent,
  output logic                   take,
  output logic                   rd_accept,
  output logic                   rd_drop,
  output logic                   wr_accept,
  output logic                   wr_drop,
  output logic [PHYS_ADDR_W-1:0] out_addr,
  output logic                   int_miss,
  output logic                   int_prot,
  output logic                   int_multi
);

  typedef enum logic [1:0] {
    ST_IDLE,     // ready for a request, waiting for its result
    ST_ACCEPT,
    ST_DROP
  } state_e;

  state_e state_q;
  logic   grant;
  logic   sent;

  // skip wins over every lookup outcome
  assign grant = match.skip | (match.any_hit & ~match.multi & ~match.prot_fail);
  assign sent  = served_write ? wr_sent : rd_sent;
  assign take  = state_q == ST_IDLE;

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      state_q   <= ST_IDLE;
      int_miss  <= 1'b0;
      int_prot  <= 1'b0;
      int_multi <= 1'b0;
    end
    else
    begin
      int_miss  <= 1'b0;
      int_prot  <= 1'b0;
      int_multi <= 1'b0;
      case (state_q)
        ST_IDLE:
        begin
          if (match_valid)
          begin
            state_q   <= grant ? ST_ACCEPT : ST_DROP;
            int_multi <= ~match.skip & match.multi;
            int_miss  <= ~match.skip & ~match.any_hit;
            int_prot  <= ~match.skip & match.any_hit & ~match.multi & match.prot_fail;
          end
        end
        default:
        begin
          if (sent)
            state_q <= ST_IDLE;   // hold until the served side has sent
        end
      endcase
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (take && match_valid)
      out_addr <= match.out_addr;
  end

  assign rd_accept = (state_q == ST_ACCEPT) & ~served_write;
  assign wr_accept = (state_q == ST_ACCEPT) & served_write;
  assign rd_drop   = (state_q == ST_DROP) & ~served_write;
  assign wr_drop   = (state_q == ST_DROP) & served_write;

endmodule

// ==== rab_core.sv ====
// top level of the remapping block: config slave, arbiter,
// slice matcher and response FSM
`timescale 1ns/1ps

module rab_core import rab_pkg::*;
(
  input  logic                   Clk_CI,
  input  logic                   Rst_RBI,
  input  axil_req_t              axil_req,
  output axil_rsp_t              axil_rsp,
  input  xlate_req_t             rd_req,
  input  logic                   rd_valid,
  input  logic                   rd_sent,
  output logic                   rd_accept,
  output logic                   rd_drop,
  input  xlate_req_t             wr_req,
  input  logic                   wr_valid,
  input  logic                   wr_sent,
  output logic                   wr_accept,
  output logic                   wr_drop,
  output logic [PHYS_ADDR_W-1:0] out_addr,
  output logic                   int_miss,
  output logic                   int_prot,
  output logic                   int_multi
);

  slice_cfg_t [N_SLICES-1:0] slice_cfg;
  lookup_t                   lookup;
  logic                      lookup_valid;
  logic                      served_write;
  match_t                    match;
  logic                      match_valid;
  logic                      take;

  rab_cfg_regs u_cfg_regs (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .slice_cfg (slice_cfg)
  );

  rab_req_arbiter u_req_arbiter (
    .Clk_CI       (Clk_CI),
    .Rst_RBI      (Rst_RBI),
    .rd_req       (rd_req),
    .wr_req       (wr_req),
    .rd_valid     (rd_valid),
    .wr_valid     (wr_valid),
    .take         (take),
    .lookup       (lookup),
    .lookup_valid (lookup_valid),
    .served_write (served_write)
  );

  rab_slice_match u_slice_match (
    .Clk_CI       (Clk_CI),
    .Rst_RBI      (Rst_RBI),
    .slice_cfg    (slice_cfg),
    .lookup       (lookup),
    .lookup_valid (lookup_valid),
    .match        (match),
    .match_valid  (match_valid)
  );

  rab_xlate_fsm u_xlate_fsm (
    .Clk_CI       (Clk_CI),
    .Rst_RBI      (Rst_RBI),
    .match        (match),
    .match_valid  (match_valid),
    .served_write (served_write),
    .rd_sent      (rd_sent),
    .wr_sent      (wr_sent),
    .take         (take),
    .rd_accept    (rd_accept),
    .rd_drop      (rd_drop),
    .wr_accept    (wr_accept),
    .wr_drop      (wr_drop),
    .out_addr     (out_addr),
    .int_miss     (int_miss),
    .int_prot     (int_prot),
    .int_multi    (int_multi)
  );

endmodule

// ==== tb_rab_core.sv ====
// testbench for the remapping block with LFSR stimulus, register shadow,
// translation reference model, compare task and watchdog
`timescale 1ns/1ps

module tb_rab_core import rab_pkg::*;
();

  localparam int N_REG_WR    = 32;
  localparam int N_RAND_REQ  = 200;
  localparam int RECFG_EVERY = 25;
  localparam int N_SKIP      = 8;
  localparam int N_DIRECTED  = 5;
  localparam int N_ALT       = 12;
  localparam int RESP_LIMIT  = 20;   // cycles to wait for any handshake
  localparam int N_XACT      = N_REG_WR + N_CFG_REGS + 2 + N_SLICES + 8 + N_DIRECTED
                               + (N_RAND_REQ / RECFG_EVERY) * N_CFG_REGS + N_RAND_REQ
                               + N_SKIP + N_ALT;

  localparam int INT_NONE  = 0;
  localparam int INT_MISS  = 1;
  localparam int INT_PROT  = 2;
  localparam int INT_MULTI = 3;

  logic                   Clk_CI;
  logic                   Rst_RBI;
  axil_req_t              axil_req;
  axil_rsp_t              axil_rsp;
  xlate_req_t             rd_req;
  xlate_req_t             wr_req;
  logic                   rd_valid;
  logic                   rd_sent;
  logic                   wr_valid;
  logic                   wr_sent;
  logic                   rd_accept;
  logic                   rd_drop;
  logic                   wr_accept;
  logic                   wr_drop;
  logic [PHYS_ADDR_W-1:0] out_addr;
  logic                   int_miss;
  logic                   int_prot;
  logic                   int_multi;

  logic [31:0]            lfsr_q;
  logic [CFG_DATA_W-1:0]  shadow [N_CFG_REGS];
  logic                   model_rd_prio;   // read side wins a tie
  int                     mism_cnt;
  int                     fail_cnt;

  rab_core uut (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .rd_req    (rd_req),
    .rd_valid  (rd_valid),
    .rd_sent   (rd_sent),
    .rd_accept (rd_accept),
    .rd_drop   (rd_drop),
    .wr_req    (wr_req),
    .wr_valid  (wr_valid),
    .wr_sent   (wr_sent),
    .wr_accept (wr_accept),
    .wr_drop   (wr_drop),
    .out_addr  (out_addr),
    .int_miss  (int_miss),
    .int_prot  (int_prot),
    .int_multi (int_multi)
  );

  always #2 Clk_CI = ~Clk_CI;

  // taps 32 22 2 1 and one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v      = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      mism_cnt++;
    end
  endtask

  function automatic xlate_req_t make_req(input logic [31:0] addr, input logic [7:0] len,
                                          input logic [2:0] size, input logic [5:0] ctrl);
    xlate_req_t r;
    r.addr = addr;
    r.len  = len;
    r.size = size;
    r.ctrl = ctrl;
    return r;
  endfunction

  function automatic xlate_req_t rand_req();
    xlate_req_t r;
    r.addr = VIRT_ADDR_W'(rand_bits(15));   // small window so slices get hit
    r.len  = LEN_W'(rand_bits(3));
    r.size = SIZE_W'(rand_bits(2));
    r.ctrl = CTRL_W'(rand_bits(6));
    return r;
  endfunction

  // last byte of the burst after beat alignment
  function automatic logic [VIRT_ADDR_W-1:0] burst_end(input xlate_req_t r);
    logic [VIRT_ADDR_W-1:0] base;
    logic [VIRT_ADDR_W-1:0] bytes;
    base = r.addr;
    if (r.size == 3'd1)
      base[0] = 1'b0;
    else if (r.size == 3'd2)
      base[1:0] = 2'b00;
    else if (r.size >= 3'd3)
      base[2:0] = 3'b000;
    bytes = (32'(r.len) + 32'd1) << r.size;
    return base + bytes - 32'd1;
  endfunction

  task automatic predict(input logic is_wr, input xlate_req_t r, output logic acc,
                         output logic [PHYS_ADDR_W-1:0] addr, output int code);
    logic [VIRT_ADDR_W-1:0] hi;
    logic [VIRT_ADDR_W-1:0] s_start;
    logic [VIRT_ADDR_W-1:0] s_last;
    logic [2:0]             fl;
    logic                   bad;
    int                     hits;
    hi   = burst_end(r);
    hits = 0;
    bad  = 1'b0;
    acc  = 1'b0;
    addr = '0;
    code = INT_NONE;
    for (int k = 0; k < N_SLICES; k++)
    begin
      s_start = shadow[k*REGS_PER_SLICE + REG_START][31:0];
      s_last  = shadow[k*REGS_PER_SLICE + REG_END][31:0];
      fl      = shadow[k*REGS_PER_SLICE + REG_FLAGS][2:0];   // wr_ok rd_ok en
      if (fl[0] && r.addr >= s_start && hi <= s_last)
      begin
        hits++;
        bad  = bad | (is_wr ? ~fl[2] : ~fl[1]);
        addr = shadow[k*REGS_PER_SLICE + REG_OFFSET][39:0] + PHYS_ADDR_W'(r.addr - s_start);
      end
    end
    if (&r.ctrl)
    begin
      acc  = 1'b1;
      addr = PHYS_ADDR_W'(r.addr);
    end
    else if (hits > 1)
      code = INT_MULTI;
    else if (hits == 0)
      code = INT_MISS;
    else if (bad)
      code = INT_PROT;
    else
      acc = 1'b1;
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] strb);
    int n;
    @(negedge Clk_CI);
    axil_req.awaddr  = addr;
    axil_req.wdata   = data;
    axil_req.wstrb   = strb;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    #1;
    check_val("awready", 64'(axil_rsp.awready), 64'd1);   // no response pending yet
    check_val("wready", 64'(axil_rsp.wready), 64'd1);
    n = 0;
    while (!axil_rsp.bvalid && n < RESP_LIMIT)
    begin
      @(negedge Clk_CI);
      n++;
    end
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    if (!axil_rsp.bvalid)
    begin
      $display("write response never came for address %h", addr);
      fail_cnt++;
    end
    else
    begin
      check_val("bresp", 64'(axil_rsp.bresp), 64'(addr < 32'h80 ? RESP_OKAY : RESP_SLVERR));
      axil_req.bready = 1'b1;
      @(negedge Clk_CI);
      axil_req.bready = 1'b0;
      check_val("bvalid", 64'(axil_rsp.bvalid), 64'd0);
    end
    if (addr < 32'h80)
    begin
      for (int b = 0; b < 8; b++)
      begin
        if (strb[b])
          shadow[addr[6:3]][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic axil_read(input logic [31:0] addr);
    int n;
    @(negedge Clk_CI);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    #1;
    check_val("arready", 64'(axil_rsp.arready), 64'd1);
    n = 0;
    while (!axil_rsp.rvalid && n < RESP_LIMIT)
    begin
      @(negedge Clk_CI);
      n++;
    end
    axil_req.arvalid = 1'b0;
    if (!axil_rsp.rvalid)
    begin
      $display("read response never came for address %h", addr);
      fail_cnt++;
    end
    else
    begin
      check_val("rresp", 64'(axil_rsp.rresp), 64'(addr < 32'h80 ? RESP_OKAY : RESP_SLVERR));
      check_val("rdata", axil_rsp.rdata, addr < 32'h80 ? shadow[addr[6:3]] : 64'd0);
      axil_req.rready = 1'b1;
      @(negedge Clk_CI);
      axil_req.rready = 1'b0;
      check_val("rvalid", 64'(axil_rsp.rvalid), 64'd0);
    end
  endtask

  // random slices with junk in the unused upper bits
  task automatic program_slices();
    logic [31:0] s;
    for (int k = 0; k < N_SLICES; k++)
    begin
      s = 32'(rand_bits(14));
      axil_write(32'(k*32), {32'(rand_bits(32)), s}, 8'hff);
      axil_write(32'(k*32 + 8), {32'(rand_bits(32)), s + 32'(rand_bits(13))}, 8'hff);
      axil_write(32'(k*32 + 16), {24'(rand_bits(24)), 40'(rand_bits(40))}, 8'hff);
      axil_write(32'(k*32 + 24), {61'(rand_bits(61)), 3'(rand_bits(3))}, 8'hff);
    end
  endtask

  task automatic wait_response(input logic exp_wr, input logic exp_acc,
                               input logic [PHYS_ADDR_W-1:0] exp_addr, input int exp_code,
                               input int exp_lat, output logic seen);
    int cycles;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < RESP_LIMIT)
    begin
      @(negedge Clk_CI);
      cycles++;
      seen = rd_accept | rd_drop | wr_accept | wr_drop;
    end
    if (!seen)
    begin
      $display("no accept or drop within %0d cycles", RESP_LIMIT);
      fail_cnt++;
    end
    else
    begin
      if (exp_lat > 0)
        check_val("latency", 64'(cycles), 64'(exp_lat));
      check_val("rd_accept", 64'(rd_accept), 64'(!exp_wr && exp_acc));
      check_val("rd_drop", 64'(rd_drop), 64'(!exp_wr && !exp_acc));
      check_val("wr_accept", 64'(wr_accept), 64'(exp_wr && exp_acc));
      check_val("wr_drop", 64'(wr_drop), 64'(exp_wr && !exp_acc));
      if (exp_acc)
        check_val("out_addr", 64'(out_addr), 64'(exp_addr));
      check_val("int_miss", 64'(int_miss), 64'(exp_code == INT_MISS));
      check_val("int_prot", 64'(int_prot), 64'(exp_code == INT_PROT));
      check_val("int_multi", 64'(int_multi), 64'(exp_code == INT_MULTI));
    end
  endtask

  // sent held back a few cycles while the response stays put
  task automatic release_response(input logic is_wr);
    logic [3:0]             held;
    logic [PHYS_ADDR_W-1:0] held_addr;
    int                     delay;
    held      = {rd_accept, rd_drop, wr_accept, wr_drop};
    held_addr = out_addr;
    delay     = int'(rand_bits(2));
    repeat (delay)
    begin
      @(negedge Clk_CI);
      check_val("held response", 64'({rd_accept, rd_drop, wr_accept, wr_drop}), 64'(held));
      check_val("held out_addr", 64'(out_addr), 64'(held_addr));
      check_val("interrupts", 64'({int_miss, int_prot, int_multi}), 64'd0);
    end
    if (is_wr)
      wr_sent = 1'b1;
    else
      rd_sent = 1'b1;
    @(negedge Clk_CI);
    rd_sent = 1'b0;
    wr_sent = 1'b0;
    check_val("response after sent", 64'({rd_accept, rd_drop, wr_accept, wr_drop}), 64'd0);
    check_val("interrupts", 64'({int_miss, int_prot, int_multi}), 64'd0);
  endtask

  task automatic run_request(input logic is_wr, input xlate_req_t r);
    logic                   acc;
    logic [PHYS_ADDR_W-1:0] addr;
    int                     code;
    logic                   seen;
    predict(is_wr, r, acc, addr, code);
    model_rd_prio = is_wr;   // served side yields
    @(negedge Clk_CI);
    if (is_wr)
    begin
      wr_req   = r;
      wr_valid = 1'b1;
    end
    else
    begin
      rd_req   = r;
      rd_valid = 1'b1;
    end
    wait_response(is_wr, acc, addr, code, 3, seen);
    rd_valid = 1'b0;
    wr_valid = 1'b0;
    if (seen)
      release_response(is_wr);
  endtask

  initial
  begin
    xlate_req_t             r;
    logic                   is_wr;
    logic                   acc;
    logic [PHYS_ADDR_W-1:0] addr;
    int                     code;
    logic                   seen;
    Clk_CI        = 1'b0;
    Rst_RBI       = 1'b0;
    axil_req      = '0;
    rd_req        = '0;
    wr_req        = '0;
    rd_valid      = 1'b0;
    rd_sent       = 1'b0;
    wr_valid      = 1'b0;
    wr_sent       = 1'b0;
    lfsr_q        = 32'h5776;
    model_rd_prio = 1'b0;   // write first out of reset
    mism_cnt      = 0;
    fail_cnt      = 0;
    for (int i = 0; i < N_CFG_REGS; i++)
      shadow[i] = '0;
    repeat (2) @(negedge Clk_CI);
    Rst_RBI = 1'b1;

    // register file with random strobes then one bad address
    for (int i = 0; i < N_REG_WR; i++)
      axil_write({25'd0, 4'(rand_bits(4)), 3'd0}, rand_bits(64), 8'(rand_bits(8)));
    axil_write(32'h80 + {24'd0, 5'(rand_bits(5)), 3'd0}, rand_bits(64), 8'hff);
    for (int i = 0; i < N_CFG_REGS; i++)
      axil_read(CFG_ADDR_W'(i * 8));
    axil_read(32'h98);

    // random translations
    for (int i = 0; i < N_RAND_REQ; i++)
    begin
      if (i % RECFG_EVERY == 0)
        program_slices();
      is_wr = 1'(rand_bits(1));
      r     = rand_req();
      run_request(is_wr, r);
    end

    // bypass with every slice disabled
    for (int k = 0; k < N_SLICES; k++)
      axil_write(32'(k*32 + 24), 64'd0, 8'hff);
    for (int i = 0; i < N_SKIP; i++)
    begin
      is_wr  = 1'(rand_bits(1));
      r      = rand_req();
      r.ctrl = '1;
      run_request(is_wr, r);
    end

    // slice 0 read only, slice 1 overlaps its top half
    axil_write(32'h00, 64'h1000, 8'hff);
    axil_write(32'h08, 64'h1fff, 8'hff);
    axil_write(32'h10, 64'h12_3400_0000, 8'hff);
    axil_write(32'h18, 64'h3, 8'hff);
    axil_write(32'h20, 64'h1800, 8'hff);
    axil_write(32'h28, 64'h2fff, 8'hff);
    axil_write(32'h30, 64'h80_0000_0000, 8'hff);
    axil_write(32'h38, 64'h7, 8'hff);
    run_request(1'b0, make_req(32'h1100, 8'd7, 3'd2, 6'd0));   // accept
    run_request(1'b1, make_req(32'h1100, 8'd0, 3'd2, 6'd0));   // prot
    run_request(1'b0, make_req(32'h1900, 8'd0, 3'd2, 6'd0));   // multi
    run_request(1'b0, make_req(32'h5000, 8'd1, 3'd0, 6'd0));   // miss
    run_request(1'b1, make_req(32'h2100, 8'd3, 3'd3, 6'd0));   // accept via slice 1

    // both channels busy so service must alternate
    @(negedge Clk_CI);
    rd_req   = rand_req();
    wr_req   = rand_req();
    rd_valid = 1'b1;
    wr_valid = 1'b1;
    for (int i = 0; i < N_ALT; i++)
    begin
      is_wr = ~model_rd_prio;
      predict(is_wr, is_wr ? wr_req : rd_req, acc, addr, code);
      model_rd_prio = is_wr;
      wait_response(is_wr, acc, addr, code, 0, seen);
      if (i == N_ALT - 1)
      begin
        rd_valid = 1'b0;
        wr_valid = 1'b0;
      end
      else if (is_wr)
        wr_req = rand_req();
      else
        rd_req = rand_req();
      if (seen)
        release_response(is_wr);
    end

    $display("checks done: %0d mismatches, %0d other errors", mism_cnt, fail_cnt);
    if (mism_cnt == 0 && fail_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    repeat (N_XACT * 40) @(posedge Clk_CI);
    $display("timeout: test sequence did not finish in %0d cycles", N_XACT * 40);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== files.f ====
rab_pkg.sv
rab_cfg_regs.sv
rab_req_arbiter.sv
rab_slice_match.sv
rab_xlate_fsm.sv
rab_core.sv
tb_rab_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the remapping block testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 -f files.f --top-module tb_rab_core -o tb_rab_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_rab_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
  exit 0
fi
exit 1
